// ==== all.f ====
src/tx_buffer_pkg.sv
src/packet_bank.sv
src/parser_write_ctrl.sv
src/dispatch_read_ctrl.sv
src/nts_tx_buffer.sv
verification/nts_tx_buffer_assert.sv
verification/tb_nts_tx_buffer.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile with Verilator, run, and pass only when the testbench prints its pass line
verilator --binary --timing --assert -Wno-fatal --top-module tb_nts_tx_buffer -f all.f \
  && ./obj_dir/Vtb_nts_tx_buffer | tee /dev/stderr | grep -x "TESTBENCH PASSED" > /dev/null \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// ==== src/dispatch_read_ctrl.sv ====
// Dispatch read controller with bank state, read pointer and registered output stream
`timescale 1ns/100ps

module dispatch_read_ctrl
  import tx_buffer_pkg::*;
#(
  parameter int ADDR_WIDTH = 8
) (
  input  logic                  i_clk,
  input  logic                  i_areset,

  input  logic                  i_current_bank,
  input  logic                  i_handover,
  input  logic                  i_rd_start,
  input  logic                  i_packet_read,

  input  word_t                 i_rd_data0,
  input  word_t                 i_rd_data1,
  input  pkt_len_t              i_len0,
  input  pkt_len_t              i_len1,

  output logic [ADDR_WIDTH-1:0] o_rd_addr,
  output logic                  o_idle,

  output logic                  o_packet_available,
  output logic                  o_fifo_empty,
  output logic                  o_rd_valid,
  output word_t                 o_rd_data,
  output bytes_last_t           o_bytes_last_word
);

  dispatch_state_e     state_q;
  logic [ADDR_WIDTH:0] rd_ptr_q;
  logic                ram_valid_q;

  word_t               rd_data_sel;
  pkt_len_t            len_sel;
  logic [ADDR_WIDTH:0] last_index;
  logic                issued_all;
  logic                addr_valid;

  // Dispatch always owns the bank the parser is not writing
  assign rd_data_sel = i_current_bank ? i_rd_data0 : i_rd_data1;
  assign len_sel     = i_current_bank ? i_len0 : i_len1;

  // Extra pointer bit keeps the compare correct for a full bank
  assign last_index  = {1'b0, len_sel.last_index[ADDR_WIDTH-1:0]};
  assign issued_all  = rd_ptr_q > last_index;
  assign addr_valid  = (state_q == D_TRANSMIT) && !issued_all;

  // --------------------------------------------------------------------------
  // Bank state and read pointer
  // --------------------------------------------------------------------------

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      state_q  <= D_EMPTY;
      rd_ptr_q <= '0;
    end else if (i_handover) begin
      state_q  <= D_AVAILABLE;
      rd_ptr_q <= '0;
    end else if (i_packet_read && (state_q != D_EMPTY)) begin
      state_q  <= D_EMPTY;
      rd_ptr_q <= '0;
    end else if (i_rd_start && (state_q == D_AVAILABLE)) begin
      state_q  <= D_TRANSMIT;
      rd_ptr_q <= '0;
    end else if (addr_valid) begin
      rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // Output stream through one RAM stage and one output stage
  // --------------------------------------------------------------------------

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      ram_valid_q        <= 1'b0;
      o_rd_valid         <= 1'b0;
      o_rd_data          <= '0;
      o_bytes_last_word  <= '0;
      o_packet_available <= 1'b0;
      o_fifo_empty       <= 1'b0;
    end else begin
      ram_valid_q        <= addr_valid;
      o_rd_valid         <= ram_valid_q;
      // Data register only loads words that are in flight
      if (ram_valid_q) begin
        o_rd_data        <= rd_data_sel;
      end
      o_bytes_last_word  <= len_sel.bytes_last;
      o_packet_available <= (state_q != D_EMPTY);
      o_fifo_empty       <= (state_q == D_TRANSMIT) && issued_all;
    end
  end

  assign o_rd_addr = rd_ptr_q[ADDR_WIDTH-1:0];
  assign o_idle    = (state_q == D_EMPTY);

endmodule

// ==== src/nts_tx_buffer.sv ====
// Transmit packet buffer top: parser and dispatch controllers around two banks
`timescale 1ns/100ps

module nts_tx_buffer
  import tx_buffer_pkg::*;
#(
  parameter int ADDR_WIDTH = 8
) (
  input  logic                  i_clk,
  input  logic                  i_areset,

  // Parser side
  input  logic                  i_write_en,
  input  word_t                 i_write_data,
  input  logic                  i_parser_update_length,
  input  logic [ADDR_WIDTH+2:0] i_length_bytes,
  input  logic                  i_parser_done,
  input  logic                  i_parser_clear,
  output logic                  o_parser_current_empty,
  output logic                  o_parser_current_memory_full,

  // Dispatch side
  input  logic                  i_rd_start,
  input  logic                  i_packet_read,
  output logic                  o_packet_available,
  output logic                  o_fifo_empty,
  output logic                  o_rd_valid,
  output word_t                 o_rd_data,
  output bytes_last_t           o_bytes_last_word
);

  bank_wr_t              wr0;
  bank_wr_t              wr1;
  logic                  len_we0;
  logic                  len_we1;
  pkt_len_t              len_wr;
  pkt_len_t              len0;
  pkt_len_t              len1;
  word_t                 rd_data0;
  word_t                 rd_data1;
  logic [ADDR_WIDTH-1:0] rd_addr;
  logic                  current_bank;
  logic                  handover;
  logic                  dispatch_idle;

  // --------------------------------------------------------------------------
  // Producer
  // --------------------------------------------------------------------------

  parser_write_ctrl #(.ADDR_WIDTH(ADDR_WIDTH)) u_parser (
    .i_clk                        (i_clk),
    .i_areset                     (i_areset),
    .i_write_en                   (i_write_en),
    .i_write_data                 (i_write_data),
    .i_parser_update_length       (i_parser_update_length),
    .i_length_bytes               (i_length_bytes),
    .i_parser_done                (i_parser_done),
    .i_parser_clear               (i_parser_clear),
    .i_dispatch_idle              (dispatch_idle),
    .o_wr0                        (wr0),
    .o_wr1                        (wr1),
    .o_len_we0                    (len_we0),
    .o_len_we1                    (len_we1),
    .o_len                        (len_wr),
    .o_current_bank               (current_bank),
    .o_handover                   (handover),
    .o_parser_current_empty       (o_parser_current_empty),
    .o_parser_current_memory_full (o_parser_current_memory_full)
  );

  // --------------------------------------------------------------------------
  // Ping-pong banks
  // --------------------------------------------------------------------------

  packet_bank #(.ADDR_WIDTH(ADDR_WIDTH)) bank0 (
    .i_clk     (i_clk),
    .i_areset  (i_areset),
    .i_wr      (wr0),
    .i_rd_addr (rd_addr),
    .o_rd_data (rd_data0),
    .i_len_we  (len_we0),
    .i_len     (len_wr),
    .o_len     (len0)
  );

  packet_bank #(.ADDR_WIDTH(ADDR_WIDTH)) bank1 (
    .i_clk     (i_clk),
    .i_areset  (i_areset),
    .i_wr      (wr1),
    .i_rd_addr (rd_addr),
    .o_rd_data (rd_data1),
    .i_len_we  (len_we1),
    .i_len     (len_wr),
    .o_len     (len1)
  );

  // --------------------------------------------------------------------------
  // Consumer
  // --------------------------------------------------------------------------

  dispatch_read_ctrl #(.ADDR_WIDTH(ADDR_WIDTH)) u_dispatch (
    .i_clk              (i_clk),
    .i_areset           (i_areset),
    .i_current_bank     (current_bank),
    .i_handover         (handover),
    .i_rd_start         (i_rd_start),
    .i_packet_read      (i_packet_read),
    .i_rd_data0         (rd_data0),
    .i_rd_data1         (rd_data1),
    .i_len0             (len0),
    .i_len1             (len1),
    .o_rd_addr          (rd_addr),
    .o_idle             (dispatch_idle),
    .o_packet_available (o_packet_available),
    .o_fifo_empty       (o_fifo_empty),
    .o_rd_valid         (o_rd_valid),
    .o_rd_data          (o_rd_data),
    .o_bytes_last_word  (o_bytes_last_word)
  );

endmodule

// ==== src/packet_bank.sv ====
// Packet bank: word RAM with registered read port and per-packet length register
`timescale 1ns/100ps

module packet_bank
  import tx_buffer_pkg::*;
#(
  parameter int ADDR_WIDTH = 8
) (
  input  logic                  i_clk,
  input  logic                  i_areset,

  // Write port, driven by the parser controller
  input  bank_wr_t              i_wr,

  // Read port, driven by the dispatch controller
  input  logic [ADDR_WIDTH-1:0] i_rd_addr,
  output word_t                 o_rd_data,

  // Length of the packet held in this bank
  input  logic                  i_len_we,
  input  pkt_len_t              i_len,
  output pkt_len_t              o_len
);

  localparam int DEPTH = 2 ** ADDR_WIDTH;

  // --------------------------------------------------------------------------
  // Storage
  // --------------------------------------------------------------------------

  word_t    mem [0:DEPTH-1];
  word_t    rd_data_q;
  pkt_len_t len_q;

  // Only the low ADDR_WIDTH bits of the struct address are meaningful
  always_ff @(posedge i_clk) begin
    if (i_wr.en) begin
      mem[i_wr.addr[ADDR_WIDTH-1:0]] <= i_wr.data;
    end
    rd_data_q <= mem[i_rd_addr];
  end

  // --------------------------------------------------------------------------
  // Length register
  // --------------------------------------------------------------------------

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      len_q <= '0;
    end else if (i_len_we) begin
      len_q <= i_len;
    end
  end

  assign o_rd_data = rd_data_q;
  assign o_len     = len_q;

endmodule

// ==== src/parser_write_ctrl.sv ====
// Parser write controller: bank state, write pointer, length decode and handover
`timescale 1ns/100ps

module parser_write_ctrl
  import tx_buffer_pkg::*;
#(
  parameter int ADDR_WIDTH = 8
) (
  input  logic                  i_clk,
  input  logic                  i_areset,

  input  logic                  i_write_en,
  input  word_t                 i_write_data,
  input  logic                  i_parser_update_length,
  input  logic [ADDR_WIDTH+2:0] i_length_bytes,
  input  logic                  i_parser_done,
  input  logic                  i_parser_clear,
  input  logic                  i_dispatch_idle,

  output bank_wr_t              o_wr0,
  output bank_wr_t              o_wr1,
  output logic                  o_len_we0,
  output logic                  o_len_we1,
  output pkt_len_t              o_len,
  output logic                  o_current_bank,
  output logic                  o_handover,
  output logic                  o_parser_current_empty,
  output logic                  o_parser_current_memory_full
);

  parser_state_e         state_q;
  logic [ADDR_WIDTH:0]   wr_ptr_q;
  logic                  cur_bank_q;

  logic                  full;
  logic                  write_ok;
  logic                  handover;
  logic                  len_we;
  bank_wr_t              wr_req;
  pkt_len_t              len_d;
  logic [ADDR_WIDTH-1:0] len_hi;
  logic [2:0]            len_lo;

  // Pointer MSB set means all 2^ADDR_WIDTH words are used
  assign full     = wr_ptr_q[ADDR_WIDTH] || (state_q == P_DONE);
  assign write_ok = i_write_en && !full;
  assign handover = (state_q == P_DONE) && i_dispatch_idle;
  assign len_we   = i_parser_update_length && (state_q != P_DONE);

  // --------------------------------------------------------------------------
  // Write request and length decode
  // --------------------------------------------------------------------------

  always_comb begin
    wr_req      = '0;
    wr_req.en   = write_ok;
    wr_req.addr[ADDR_WIDTH-1:0] = wr_ptr_q[ADDR_WIDTH-1:0];
    wr_req.data = i_write_data;
  end

  always_comb begin
    len_hi = i_length_bytes[ADDR_WIDTH+2:3];
    len_lo = i_length_bytes[2:0];
    len_d  = '0;
    if (len_lo != 3'd0) begin
      len_d.last_index[ADDR_WIDTH-1:0] = len_hi;
      len_d.bytes_last = {1'b0, len_lo};
    end else if (len_hi != '0) begin
      // Whole number of words, last one fully used
      len_d.last_index[ADDR_WIDTH-1:0] = len_hi - 1'b1;
      len_d.bytes_last = 4'd8;
    end
  end

  // --------------------------------------------------------------------------
  // Bank state and pointer
  // --------------------------------------------------------------------------

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      state_q    <= P_EMPTY;
      wr_ptr_q   <= '0;
      cur_bank_q <= 1'b0;
    end else if (handover) begin
      cur_bank_q <= ~cur_bank_q;
      state_q    <= P_EMPTY;
      wr_ptr_q   <= '0;
    end else if (i_parser_clear) begin
      state_q    <= P_EMPTY;
      wr_ptr_q   <= '0;
    end else begin
      if (write_ok) begin
        state_q  <= P_HAS_DATA;
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      // Done overrides a write in the same cycle, the word is still stored
      if (i_parser_done && (state_q != P_DONE)) begin
        state_q <= P_DONE;
      end
    end
  end

  // Only the current bank sees write and length enables
  always_comb begin
    o_wr0        = wr_req;
    o_wr1        = wr_req;
    o_wr0.en     = wr_req.en && !cur_bank_q;
    o_wr1.en     = wr_req.en && cur_bank_q;
  end

  assign o_len_we0                    = len_we && !cur_bank_q;
  assign o_len_we1                    = len_we && cur_bank_q;
  assign o_len                        = len_d;
  assign o_current_bank               = cur_bank_q;
  assign o_handover                   = handover;
  assign o_parser_current_empty       = (state_q == P_EMPTY);
  assign o_parser_current_memory_full = full;

endmodule

// ==== src/tx_buffer_pkg.sv ====
// Shared word, length and bank write types plus the bank state encodings
package tx_buffer_pkg;

  // Widest address supported by the struct fields below
  localparam int ADDR_WIDTH_MAX = 8;

  // One packet word as written by the parser and read by dispatch
  typedef logic [63:0] word_t;

  // Valid bytes in the last word of a packet, 0 to 8
  typedef logic [3:0] bytes_last_t;

  // Stored packet length, kept per bank
  typedef struct packed {
    logic [ADDR_WIDTH_MAX-1:0] last_index;
    bytes_last_t               bytes_last;
  } pkt_len_t;

  // Single write request to a packet bank
  typedef struct packed {
    logic                      en;
    logic [ADDR_WIDTH_MAX-1:0] addr;
    word_t                     data;
  } bank_wr_t;

  // Bank state seen from the parser side
  typedef enum logic [1:0] {P_EMPTY, P_HAS_DATA, P_DONE} parser_state_e;

  // Bank state seen from the dispatch side
  typedef enum logic [1:0] {D_EMPTY, D_AVAILABLE, D_TRANSMIT} dispatch_state_e;

endpackage

// ==== verification/nts_tx_buffer_assert.sv ====
// Concurrent assertions on the transmit buffer outputs, bound to the top level
`timescale 1ns/100ps

module nts_tx_buffer_assert (
  input logic i_clk,
  input logic i_areset,
  input logic i_packet_available,
  input logic i_fifo_empty,
  input logic i_rd_valid,
  input logic i_memory_full
);

  // A word is only streamed while a packet is held by dispatch
  property p_valid_in_packet;
    @(posedge i_clk) disable iff (i_areset)
      i_rd_valid |-> i_packet_available;
  endproperty

  // End-of-packet flag only inside a packet
  property p_empty_in_packet;
    @(posedge i_clk) disable iff (i_areset)
      i_fifo_empty |-> i_packet_available;
  endproperty

  property p_quiet_in_reset;
    @(posedge i_clk)
      i_areset |-> !(i_packet_available || i_fifo_empty || i_rd_valid || i_memory_full);
  endproperty

  a_valid_in_packet: assert property (p_valid_in_packet)
    else $error("o_rd_valid high while no packet is available");
  a_empty_in_packet: assert property (p_empty_in_packet)
    else $error("o_fifo_empty high while no packet is available");
  a_quiet_in_reset: assert property (p_quiet_in_reset)
    else $error("Control output high during reset");

endmodule

bind nts_tx_buffer nts_tx_buffer_assert u_assert (
  .i_clk              (i_clk),
  .i_areset           (i_areset),
  .i_packet_available (o_packet_available),
  .i_fifo_empty       (o_fifo_empty),
  .i_rd_valid         (o_rd_valid),
  .i_memory_full      (o_parser_current_memory_full)
);

// ==== verification/tb_nts_tx_buffer.sv ====
// Testbench with clock, reset, LFSR stimulus, length reference model, scoreboard and watchdog
`timescale 1ns/100ps

module tb_nts_tx_buffer
  import tx_buffer_pkg::*;
();

  localparam int ADDR_WIDTH         = 4;
  localparam int DEPTH              = 2 ** ADDR_WIDTH;
  localparam int LEN_WIDTH          = ADDR_WIDTH + 3;
  localparam int CLK_PERIOD         = 10;
  localparam int DRIVE_DELAY        = 1;
  localparam int RESET_CYCLES       = 10;
  localparam int NUM_EDGE_LENGTHS   = 18;
  localparam int NUM_RANDOM_LENGTHS = 8;
  // Packets of the single, double-buffered, full bank and clear tests and the length sweep
  localparam int NUM_PACKETS        = 5 + NUM_EDGE_LENGTHS + NUM_RANDOM_LENGTHS;
  localparam int CYCLES_PER_PACKET  = 200;
  localparam logic [31:0] LFSR_SEED = 32'h52a5_ca7e;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  typedef logic [LEN_WIDTH-1:0] len_bytes_t;

  logic        i_clk;
  logic        i_areset;
  logic        i_write_en;
  word_t       i_write_data;
  logic        i_parser_update_length;
  len_bytes_t  i_length_bytes;
  logic        i_parser_done;
  logic        i_parser_clear;
  logic        i_rd_start;
  logic        i_packet_read;
  logic        o_parser_current_empty;
  logic        o_parser_current_memory_full;
  logic        o_packet_available;
  logic        o_fifo_empty;
  logic        o_rd_valid;
  word_t       o_rd_data;
  bytes_last_t o_bytes_last_word;

  logic [31:0] lfsr_q;
  word_t       exp_words[$];
  pkt_len_t    exp_lens[$];
  int unsigned packets_done = 0;

  nts_tx_buffer #(.ADDR_WIDTH(ADDR_WIDTH)) DUT (
    .i_clk                        (i_clk),
    .i_areset                     (i_areset),
    .i_write_en                   (i_write_en),
    .i_write_data                 (i_write_data),
    .i_parser_update_length       (i_parser_update_length),
    .i_length_bytes               (i_length_bytes),
    .i_parser_done                (i_parser_done),
    .i_parser_clear               (i_parser_clear),
    .o_parser_current_empty       (o_parser_current_empty),
    .o_parser_current_memory_full (o_parser_current_memory_full),
    .i_rd_start                   (i_rd_start),
    .i_packet_read                (i_packet_read),
    .o_packet_available           (o_packet_available),
    .o_fifo_empty                 (o_fifo_empty),
    .o_rd_valid                   (o_rd_valid),
    .o_rd_data                    (o_rd_data),
    .o_bytes_last_word            (o_bytes_last_word)
  );

  initial begin : clock_gen
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  // --------------------------------------------------------------------------
  // Reference model and random source
  // --------------------------------------------------------------------------

  // Last word index and valid byte count for a length in bytes
  // Zero length still occupies one empty word
  function automatic pkt_len_t expected_len(input int unsigned len_bytes);
    int unsigned words;
    int unsigned tail;
    pkt_len_t    r;
    words = len_bytes / 8;
    tail  = len_bytes % 8;
    r     = '0;
    if (len_bytes == 0) begin
      r.last_index = '0;
      r.bytes_last = '0;
    end else if (tail == 0) begin
      r.last_index = ADDR_WIDTH_MAX'(words - 1);
      r.bytes_last = bytes_last_t'(8);
    end else begin
      r.last_index = ADDR_WIDTH_MAX'(words);
      r.bytes_last = bytes_last_t'(tail);
    end
    return r;
  endfunction

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic random_bits(input int n, output logic [63:0] r);
    r = '0;
    for (int i = 0; i < n; i++) begin
      r      = {r[62:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  task automatic random_length(output int unsigned len_bytes);
    logic [63:0] r;
    random_bits(LEN_WIDTH, r);
    len_bytes = int'(r[LEN_WIDTH-1:0]);
  endtask

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------

  task automatic report_failure();
    $display("TESTBENCH FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_word(input word_t actual, input word_t expected, input string what);
    if (actual !== expected) begin
      $display("FAIL at %0t ns: %s is 0x%h, expected 0x%h", $time, what, actual, expected);
      report_failure();
    end
  endtask

  task automatic check_bytes_last(input bytes_last_t actual, input bytes_last_t expected,
                                  input string what);
    if (actual !== expected) begin
      $display("FAIL at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
      report_failure();
    end
  endtask

  task automatic check_flag(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      $display("FAIL at %0t ns: %s is %b, expected %b", $time, what, actual, expected);
      report_failure();
    end
  endtask

  // Checks every streamed word against the scoreboard and the length at the last word
  initial begin : compare_stream
    int unsigned word_count;
    pkt_len_t    cur_len;
    word_count = 0;
    forever begin
      @(negedge i_clk);
      if (o_rd_valid) begin
        if (exp_words.size() == 0 || exp_lens.size() == 0) begin
          $display("Unexpected word on o_rd_data at %0t ns with no packet expected", $time);
          report_failure();
        end else begin
          cur_len = exp_lens[0];
          check_word(o_rd_data, exp_words.pop_front(), "o_rd_data");
          word_count++;
          if (word_count == cur_len.last_index + 1) begin
            check_bytes_last(o_bytes_last_word, cur_len.bytes_last, "o_bytes_last_word");
            check_flag(o_fifo_empty, 1'b1, "o_fifo_empty at last word");
            void'(exp_lens.pop_front());
            word_count = 0;
            packets_done++;
          end else begin
            check_flag(o_fifo_empty, 1'b0, "o_fifo_empty before last word");
          end
        end
      end
    end
  end

  initial begin : watchdog
    #((RESET_CYCLES + CYCLES_PER_PACKET * NUM_PACKETS) * CLK_PERIOD);
    $display("Watchdog expired at %0t ns, the tests did not complete in time", $time);
    report_failure();
  end

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------

  // Waits for the next drive point and returns all strobes low
  task automatic step();
    @(posedge i_clk);
    #DRIVE_DELAY;
    i_write_en             = 1'b0;
    i_parser_update_length = 1'b0;
    i_parser_done          = 1'b0;
    i_parser_clear         = 1'b0;
    i_rd_start             = 1'b0;
    i_packet_read          = 1'b0;
  endtask

  task automatic write_word(input word_t w);
    step();
    i_write_en   = 1'b1;
    i_write_data = w;
  endtask

  // Length and done share one strobe cycle
  task automatic finish_packet(input int unsigned len_bytes);
    step();
    i_parser_update_length = 1'b1;
    i_length_bytes         = len_bytes_t'(len_bytes);
    i_parser_done          = 1'b1;
    exp_lens.push_back(expected_len(len_bytes));
  endtask

  task automatic send_packet(input int unsigned len_bytes);
    pkt_len_t    len;
    logic [63:0] w;
    len = expected_len(len_bytes);
    for (int i = 0; i <= int'(len.last_index); i++) begin
      random_bits(64, w);
      write_word(w);
      exp_words.push_back(w);
    end
    finish_packet(len_bytes);
  endtask

  task automatic read_packet();
    int unsigned target;
    target = packets_done + 1;
    step();
    while (!o_packet_available) step();
    i_rd_start = 1'b1;
    while (packets_done < target) step();
    i_packet_read = 1'b1;
    step();
    step();
    check_flag(o_packet_available, 1'b0, "o_packet_available after i_packet_read");
  endtask

  initial begin : main
    int unsigned len;
    int unsigned lengths[$];
    logic [63:0] w;

    lfsr_q                 = LFSR_SEED;
    i_areset               = 1'b0;
    i_write_en             = 1'b0;
    i_write_data           = '0;
    i_parser_update_length = 1'b0;
    i_length_bytes         = '0;
    i_parser_done          = 1'b0;
    i_parser_clear         = 1'b0;
    i_rd_start             = 1'b0;
    i_packet_read          = 1'b0;

    // Reset rises after time zero so the asynchronous edge is seen
    #DRIVE_DELAY;
    i_areset = 1'b1;
    repeat (RESET_CYCLES) @(posedge i_clk);
    #DRIVE_DELAY;
    i_areset = 1'b0;
    step();
    check_flag(o_packet_available, 1'b0, "o_packet_available after reset");
    check_flag(o_fifo_empty, 1'b0, "o_fifo_empty after reset");
    check_flag(o_rd_valid, 1'b0, "o_rd_valid after reset");
    check_flag(o_parser_current_memory_full, 1'b0, "o_parser_current_memory_full after reset");
    check_flag(o_parser_current_empty, 1'b1, "o_parser_current_empty after reset");
    check_word(o_rd_data, '0, "o_rd_data after reset");
    check_bytes_last(o_bytes_last_word, '0, "o_bytes_last_word after reset");

    // Single packet reaches dispatch within three cycles of done
    random_length(len);
    send_packet(len);
    repeat (3) step();
    check_flag(o_packet_available, 1'b1, "o_packet_available three cycles after done");
    read_packet();

    // Second packet waits in the other bank while the first is held
    random_length(len);
    send_packet(len);
    step();
    while (!o_packet_available) step();
    check_flag(o_parser_current_empty, 1'b1, "o_parser_current_empty after handover");
    random_length(len);
    send_packet(len);
    read_packet();
    read_packet();

    // Extra write into a full bank is dropped
    for (int i = 0; i < DEPTH; i++) begin
      random_bits(64, w);
      write_word(w);
      exp_words.push_back(w);
    end
    step();
    check_flag(o_parser_current_memory_full, 1'b1, "o_parser_current_memory_full");
    random_bits(64, w);
    write_word(w);
    finish_packet(DEPTH * 8 - 1);
    read_packet();

    // Clear discards a partial packet
    for (int i = 0; i < 3; i++) begin
      random_bits(64, w);
      write_word(w);
    end
    step();
    check_flag(o_parser_current_empty, 1'b0, "o_parser_current_empty before clear");
    i_parser_clear = 1'b1;
    step();
    check_flag(o_parser_current_empty, 1'b1, "o_parser_current_empty after clear");
    random_length(len);
    send_packet(len);
    read_packet();

    // Length sweep ends at 127 as the 7-bit length port holds no larger value
    lengths.push_back(0);
    lengths.push_back(8);
    lengths.push_back(9);
    for (int l = 16; l <= 120; l += 8) begin
      lengths.push_back(l);
    end
    lengths.push_back(127);
    for (int i = 0; i < NUM_RANDOM_LENGTHS; i++) begin
      random_length(len);
      lengths.push_back(len);
    end
    foreach (lengths[i]) begin
      send_packet(lengths[i]);
      read_packet();
    end

    repeat (4) step();
    if (exp_words.size() != 0 || exp_lens.size() != 0) begin
      $display("Scoreboard not empty at the end: %0d words and %0d lengths left",
               exp_words.size(), exp_lens.size());
      report_failure();
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule
